//--- verilog/fetch_macros.svh
// Width, depth and trap-vector field macros for the fetch stage
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

////////////////////////////////////////
// Datapath
////////////////////////////////////////

// Address and instruction word width
`define FETCH_XLEN 32

// Entries in the instruction queue
`define FETCH_QUEUE_DEPTH 2

////////////////////////////////////////
// Trap vectors
////////////////////////////////////////

// Upper bits of mtvec used as the vector base
`define MTVEC_BASE_WIDTH 25

// Interrupt index placed in the vectored address
`define IRQ_ID_WIDTH 5

`endif

//--- verilog/fetch_pkg.sv
// Fetch stage types: PC source enum, queue entry and IF/ID pipe structs
`include "fetch_macros.svh"

package fetch_pkg;

  ////////////////////////////////////////
  // Next-PC source
  ////////////////////////////////////////

  // Chosen by the controller together with pc_set
  typedef enum logic [2:0] {
    PC_BOOT     = 3'd0,
    PC_JUMP     = 3'd1,
    PC_BRANCH   = 3'd2,
    PC_MRET     = 3'd3,
    PC_WB_PLUS4 = 3'd4,
    PC_TRAP_EXC = 3'd5,
    PC_TRAP_IRQ = 3'd6
  } pc_mux_e;

  ////////////////////////////////////////
  // Datapath records
  ////////////////////////////////////////

  // One fetched word as returned by the bus
  typedef struct packed {
    logic [`FETCH_XLEN-1:0] pc;
    logic [`FETCH_XLEN-1:0] instr;
    logic                   err;
  } fetch_entry_t;

  // Contents of the IF/ID pipeline register
  typedef struct packed {
    logic                   instr_valid;
    logic [`FETCH_XLEN-1:0] pc;
    logic [`FETCH_XLEN-1:0] instr;
    logic                   abort_op;
  } if_id_pipe_t;

endpackage

//--- verilog/fetch_resp_if.sv
// Fetch response channel from the bus master into the instruction queue
interface fetch_resp_if
  import fetch_pkg::*;
();

  // Entry offered by the master
  logic         valid;
  fetch_entry_t entry;

  // Queue has room
  logic         ready;

  // Redirect in progress so everything is dropped
  logic         flush;

  // Bus master side
  modport producer (
    output valid, entry,
    input  ready, flush
  );

  // Queue side
  modport consumer (
    input  valid, entry, flush,
    output ready
  );

endinterface

//--- verilog/fetch_pc_select.sv
// Next fetch address selection and the mtvec-init strobe
`include "fetch_macros.svh"

module fetch_pc_select
  import fetch_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst_n,
  input  pc_mux_e                      pc_mux_i,
  input  logic                         pc_set_i,
  input  logic [`FETCH_XLEN-1:0]       boot_addr_i,
  input  logic [`FETCH_XLEN-1:0]       jump_target_i,
  input  logic [`FETCH_XLEN-1:0]       branch_target_i,
  input  logic [`FETCH_XLEN-1:0]       mepc_i,
  input  logic [`FETCH_XLEN-1:0]       pipe_pc_i,
  input  logic [`MTVEC_BASE_WIDTH-1:0] mtvec_addr_i,
  input  logic [`IRQ_ID_WIDTH-1:0]     irq_id_i,
  output logic [`FETCH_XLEN-1:0]       branch_addr_o,
  output logic                         csr_mtvec_init_o
);

  logic mtvec_init_q;

  // Target address mux
  always_comb begin
    case (pc_mux_i)
      PC_JUMP:     branch_addr_o = jump_target_i;
      PC_BRANCH:   branch_addr_o = branch_target_i;
      PC_MRET:     branch_addr_o = mepc_i;
      PC_WB_PLUS4: branch_addr_o = pipe_pc_i;
      // Exceptions share the vector base
      PC_TRAP_EXC: branch_addr_o = {mtvec_addr_i, 7'h00};
      // Interrupts are vectored by id
      PC_TRAP_IRQ: branch_addr_o = {mtvec_addr_i, irq_id_i, 2'b00};
      // Boot, and the unused encoding, start word aligned
      default:     branch_addr_o = {boot_addr_i[`FETCH_XLEN-1:2], 2'b00};
    endcase
  end

  // One-cycle request to the CSR file after a boot redirect
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mtvec_init_q <= 1'b0;
    end else begin
      mtvec_init_q <= pc_set_i && (pc_mux_i == PC_BOOT);
    end
  end

  assign csr_mtvec_init_o = mtvec_init_q;

  // Controller must give a defined source with every redirect
  a_pc_mux_known: assert property (@(posedge clk) disable iff (!rst_n)
    pc_set_i |-> !$isunknown(pc_mux_i));

endmodule

//--- verilog/wb_fetch_master.sv
// Wishbone classic read master with fetch address counter and redirect discard
`include "fetch_macros.svh"

module wb_fetch_master
  import fetch_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   pc_set_i,
  input  logic [`FETCH_XLEN-1:0] branch_addr_i,
  fetch_resp_if.producer         resp,
  output logic                   wb_cyc_o,
  output logic                   wb_stb_o,
  output logic [`FETCH_XLEN-1:0] wb_adr_o,
  input  logic [`FETCH_XLEN-1:0] wb_dat_i,
  input  logic                   wb_ack_i,
  input  logic                   wb_err_i,
  output logic                   busy_o,
  output logic [`FETCH_XLEN-1:0] pc_if_o
);

  logic [`FETCH_XLEN-1:0] fetch_addr_q;
  logic [`FETCH_XLEN-1:0] adr_q;
  logic                   cyc_q;
  logic                   discard_q;
  logic                   bus_done;
  logic                   start;
  logic                   accept;
  fetch_entry_t           resp_entry;

  // Cycle ends on either ack or err
  assign bus_done = cyc_q && (wb_ack_i || wb_err_i);
  // Only one cycle in flight, and only with room in the queue
  assign start    = !cyc_q && resp.ready && !pc_set_i;
  // Stale data from before a redirect never leaves here
  assign resp.valid = bus_done && !discard_q;
  assign accept   = resp.valid && resp.ready && !resp.flush;

  always_comb begin
    resp_entry.pc    = adr_q;
    resp_entry.instr = wb_dat_i;
    resp_entry.err   = wb_err_i;
  end
  assign resp.entry = resp_entry;

  ////////////////////////////////////////
  // Bus cycle control
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cyc_q        <= 1'b0;
      discard_q    <= 1'b0;
      fetch_addr_q <= '0;
    end else begin
      if (start) begin
        cyc_q <= 1'b1;
      end else if (bus_done) begin
        cyc_q <= 1'b0;
      end
      // Mark a pending cycle as stale on redirect
      if (bus_done) begin
        discard_q <= 1'b0;
      end else if (pc_set_i && cyc_q) begin
        discard_q <= 1'b1;
      end
      if (pc_set_i) begin
        fetch_addr_q <= branch_addr_i;
      end else if (accept) begin
        fetch_addr_q <= fetch_addr_q + `FETCH_XLEN'(4);
      end
    end
  end

  // Address held for the whole cycle
  always_ff @(posedge clk) begin
    if (start) begin
      adr_q <= fetch_addr_q;
    end
  end

  assign wb_cyc_o = cyc_q;
  assign wb_stb_o = cyc_q;
  assign wb_adr_o = adr_q;
  assign busy_o   = cyc_q;
  assign pc_if_o  = fetch_addr_q;

  // Slave answers only inside a cycle
  a_resp_in_cyc: assert property (@(posedge clk) disable iff (!rst_n)
    (wb_ack_i || wb_err_i) |-> wb_cyc_o);

  // Request stays put until the slave answers
  a_adr_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (wb_stb_o && !wb_ack_i && !wb_err_i) |=> (wb_stb_o && $stable(wb_adr_o)));

endmodule

//--- verilog/fetch_queue.sv
// Instruction queue FIFO with flush and kill, driving the IF stage valid
`include "fetch_macros.svh"

module fetch_queue
  import fetch_pkg::*;
(
  input  logic           clk,
  input  logic           rst_n,
  fetch_resp_if.consumer resp,
  input  logic           halt_i,
  input  logic           kill_i,
  input  logic           id_ready_i,
  output fetch_entry_t   entry_o,
  output logic           valid_o
);

  localparam int unsigned PTR_W = $clog2(`FETCH_QUEUE_DEPTH);
  localparam int unsigned CNT_W = $clog2(`FETCH_QUEUE_DEPTH + 1);

  fetch_entry_t     mem [`FETCH_QUEUE_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             clear;
  logic             push;
  logic             pop;

  // Wrapping pointer step
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(`FETCH_QUEUE_DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
  endfunction

  assign clear      = resp.flush || kill_i;
  assign resp.ready = (count_q != CNT_W'(`FETCH_QUEUE_DEPTH));
  assign push       = resp.valid && resp.ready && !clear;
  assign valid_o    = (count_q != '0) && !halt_i && !kill_i;
  assign pop        = valid_o && id_ready_i;
  assign entry_o    = mem[rd_ptr_q];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clear) begin
      // Redirect or kill drops all buffered words
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= ptr_next(wr_ptr_q);
      if (pop) rd_ptr_q <= ptr_next(rd_ptr_q);
      case ({push, pop})
        2'b10:   count_q <= count_q + CNT_W'(1);
        2'b01:   count_q <= count_q - CNT_W'(1);
        default: count_q <= count_q;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr_q] <= resp.entry;
    end
  end

  // Master must only have a cycle in flight with room reserved here
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    (resp.valid && !resp.flush) |-> resp.ready);

endmodule

//--- verilog/if_id_register.sv
// IF/ID pipeline register with abort marking and back-pressure freeze
`include "fetch_macros.svh"

module if_id_register
  import fetch_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         valid_i,
  input  fetch_entry_t entry_i,
  input  logic         id_ready_i,
  input  logic         kill_i,
  output if_id_pipe_t  if_id_o
);

  logic                   instr_valid_q;
  logic [`FETCH_XLEN-1:0] pc_q;
  logic [`FETCH_XLEN-1:0] instr_q;
  logic                   abort_q;
  logic                   load;

  // Transfer into ID
  assign load = valid_i && id_ready_i;

  ////////////////////////////////////////
  // Valid bit
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      instr_valid_q <= 1'b0;
    end else if (kill_i) begin
      instr_valid_q <= 1'b0;
    end else if (load) begin
      instr_valid_q <= 1'b1;
    end else if (id_ready_i) begin
      // ID consumed it and nothing new came
      instr_valid_q <= 1'b0;
    end
  end

  // Payload frozen unless a new word moves in
  always_ff @(posedge clk) begin
    if (load) begin
      pc_q    <= entry_i.pc;
      instr_q <= entry_i.instr;
      // Bus error makes ID raise an access fault
      abort_q <= entry_i.err;
    end
  end

  assign if_id_o = '{instr_valid: instr_valid_q, pc: pc_q, instr: instr_q, abort_op: abort_q};

endmodule

//--- verilog/if_stage.sv
// Fetch stage top: address select, Wishbone master, queue and IF/ID register
`include "fetch_macros.svh"

module if_stage
  import fetch_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst_n,
  // Redirect control and targets
  input  pc_mux_e                      pc_mux_i,
  input  logic                         pc_set_i,
  input  logic [`FETCH_XLEN-1:0]       boot_addr_i,
  input  logic [`FETCH_XLEN-1:0]       jump_target_i,
  input  logic [`FETCH_XLEN-1:0]       branch_target_i,
  input  logic [`FETCH_XLEN-1:0]       mepc_i,
  input  logic [`FETCH_XLEN-1:0]       pipe_pc_i,
  input  logic [`MTVEC_BASE_WIDTH-1:0] mtvec_addr_i,
  input  logic [`IRQ_ID_WIDTH-1:0]     irq_id_i,
  input  logic                         halt_if_i,
  input  logic                         kill_if_i,
  input  logic                         id_ready_i,
  // Wishbone instruction bus
  output logic                         wb_cyc_o,
  output logic                         wb_stb_o,
  output logic [`FETCH_XLEN-1:0]       wb_adr_o,
  input  logic [`FETCH_XLEN-1:0]       wb_dat_i,
  input  logic                         wb_ack_i,
  input  logic                         wb_err_i,
  // IF/ID outputs and status
  output logic                         if_id_instr_valid_o,
  output logic [`FETCH_XLEN-1:0]       if_id_pc_o,
  output logic [`FETCH_XLEN-1:0]       if_id_instr_o,
  output logic                         if_id_abort_o,
  output logic [`FETCH_XLEN-1:0]       pc_if_o,
  output logic                         if_busy_o,
  output logic                         csr_mtvec_init_o,
  output logic                         if_valid_o
);

  logic [`FETCH_XLEN-1:0] branch_addr;
  fetch_entry_t           queue_entry;
  if_id_pipe_t            if_id;

  fetch_resp_if resp_if ();

  // Any redirect empties the queue
  assign resp_if.flush = pc_set_i;

  fetch_pc_select fetch_pc_select_inst (
    .clk, .rst_n, .pc_mux_i, .pc_set_i, .boot_addr_i, .jump_target_i,
    .branch_target_i, .mepc_i, .pipe_pc_i, .mtvec_addr_i, .irq_id_i,
    .branch_addr_o    (branch_addr),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  wb_fetch_master wb_fetch_master_inst (
    .clk, .rst_n, .pc_set_i,
    .branch_addr_i (branch_addr),
    .resp          (resp_if.producer),
    .wb_cyc_o, .wb_stb_o, .wb_adr_o, .wb_dat_i, .wb_ack_i, .wb_err_i,
    .busy_o        (if_busy_o),
    .pc_if_o       (pc_if_o)
  );

  fetch_queue fetch_queue_inst (
    .clk, .rst_n,
    .resp       (resp_if.consumer),
    .halt_i     (halt_if_i),
    .kill_i     (kill_if_i),
    .id_ready_i (id_ready_i),
    .entry_o    (queue_entry),
    .valid_o    (if_valid_o)
  );

  if_id_register if_id_register_inst (
    .clk, .rst_n,
    .valid_i    (if_valid_o),
    .entry_i    (queue_entry),
    .id_ready_i (id_ready_i),
    .kill_i     (kill_if_i),
    .if_id_o    (if_id)
  );

  // Flatten pipe record onto the top ports
  assign if_id_instr_valid_o = if_id.instr_valid;
  assign if_id_pc_o          = if_id.pc;
  assign if_id_instr_o       = if_id.instr;
  assign if_id_abort_o       = if_id.abort_op;

endmodule

//--- tb/wb_mem_model.sv
// Wishbone read slave model with LFSR wait states, address-derived data and an error region
`include "fetch_macros.svh"

module wb_mem_model (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   cyc_i,
  input  logic                   stb_i,
  input  logic [`FETCH_XLEN-1:0] adr_i,
  output logic [`FETCH_XLEN-1:0] dat_o,
  output logic                   ack_o,
  output logic                   err_o
);

  timeunit 1ns;
  timeprecision 100ps;

  logic [31:0] lfsr_q;
  logic [1:0]  wait_q;
  logic        busy_q;

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  // Every address bit shows up in the returned word
  assign dat_o = adr_i ^ 32'hA5A5_0000;

  always @(posedge clk or negedge rst_n) begin
    logic [31:0] s1;
    logic [31:0] s2;
    if (!rst_n) begin
      ack_o  <= 1'b0;
      err_o  <= 1'b0;
      busy_q <= 1'b0;
      wait_q <= 2'd0;
      lfsr_q <= 32'h657e;
    end else begin
      // Response lasts one cycle
      ack_o <= 1'b0;
      err_o <= 1'b0;
      if (cyc_i && stb_i && !ack_o && !err_o) begin
        if (!busy_q) begin
          // Two LFSR steps give a 0 to 3 wait count
          s1 = lfsr_next(lfsr_q);
          s2 = lfsr_next(s1);
          lfsr_q <= s2;
          wait_q <= {s1[0], s2[0]};
          busy_q <= 1'b1;
        end else if (wait_q != 2'd0) begin
          wait_q <= wait_q - 2'd1;
        end else begin
          busy_q <= 1'b0;
          // 0x0000_F000 to 0x0000_FFFF answers with err
          if (adr_i[31:12] == 20'h0000F) begin
            err_o <= 1'b1;
          end else begin
            ack_o <= 1'b1;
          end
        end
      end
    end
  end

endmodule

//--- tb/tb_if_stage.sv
// Fetch stage testbench: clock, reset, redirect sequences, reference pc model and checks
`include "fetch_macros.svh"

module tb_if_stage
  import fetch_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [`FETCH_XLEN-1:0] DATA_MASK = 32'hA5A5_0000;

  logic                         clk = 1'b0;
  logic                         rst_n;
  pc_mux_e                      pc_mux_i;
  logic                         pc_set_i;
  logic [`FETCH_XLEN-1:0]       boot_addr_i;
  logic [`FETCH_XLEN-1:0]       jump_target_i;
  logic [`FETCH_XLEN-1:0]       branch_target_i;
  logic [`FETCH_XLEN-1:0]       mepc_i;
  logic [`FETCH_XLEN-1:0]       pipe_pc_i;
  logic [`MTVEC_BASE_WIDTH-1:0] mtvec_addr_i;
  logic [`IRQ_ID_WIDTH-1:0]     irq_id_i;
  logic                         halt_if_i;
  logic                         kill_if_i;
  logic                         id_ready_i = 1'b0;
  logic                         wb_cyc_o;
  logic                         wb_stb_o;
  logic [`FETCH_XLEN-1:0]       wb_adr_o;
  logic [`FETCH_XLEN-1:0]       wb_dat_i;
  logic                         wb_ack_i;
  logic                         wb_err_i;
  logic                         if_id_instr_valid_o;
  logic [`FETCH_XLEN-1:0]       if_id_pc_o;
  logic [`FETCH_XLEN-1:0]       if_id_instr_o;
  logic                         if_id_abort_o;
  logic [`FETCH_XLEN-1:0]       pc_if_o;
  logic                         if_busy_o;
  logic                         csr_mtvec_init_o;
  logic                         if_valid_o;

  // Reference pc and bookkeeping
  logic [`FETCH_XLEN-1:0] exp_pc = '0;
  logic [`FETCH_XLEN-1:0] redirect_pc = '0;
  logic [65:0]            held_q = '0;
  logic                   hold_q = 1'b0;
  logic                   redirect_q = 1'b0;
  logic                   boot_set_q = 1'b0;
  logic [31:0]            lfsr_q = 32'h657e;
  logic                   random_ready;
  logic                   ready_level;
  logic                   end_check;
  int                     consumed = 0;
  int                     mtvec_pulses = 0;
  int                     error_count = 0;
  int                     timeout_count = 0;
  string                  test_name;

  always #2 clk = ~clk;

  if_stage if_stage_inst (.*);

  wb_mem_model wb_mem_model_inst (
    .clk, .rst_n,
    .cyc_i (wb_cyc_o),
    .stb_i (wb_stb_o),
    .adr_i (wb_adr_o),
    .dat_o (wb_dat_i),
    .ack_o (wb_ack_i),
    .err_o (wb_err_i)
  );

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  function automatic logic in_err_region(input logic [`FETCH_XLEN-1:0] addr);
    return addr[31:12] == 20'h0000F;
  endfunction

  task automatic show_mismatch(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
    $display("Mismatch %s %s: expected %h, actual %h", test_name, what, exp, act);
    error_count++;
  endtask

  task automatic note_failure(input string msg);
    $display("Error in %s: %s", test_name, msg);
    error_count++;
  endtask

  // Redirect with an IF kill just as the controller issues it
  task automatic redirect(input string name, input pc_mux_e src,
                          input logic [`FETCH_XLEN-1:0] target);
    test_name   <= name;
    pc_mux_i    <= src;
    redirect_pc <= target;
    pc_set_i    <= 1'b1;
    kill_if_i   <= 1'b1;
    @(posedge clk);
    pc_set_i  <= 1'b0;
    kill_if_i <= 1'b0;
  endtask

  task automatic wait_fetches(input int n);
    int start_count;
    int cycles;
    start_count = consumed;
    cycles = 0;
    while (consumed < start_count + n && cycles < 50 * n) begin
      @(posedge clk);
      cycles++;
    end
    if (consumed < start_count + n) begin
      $display("Timeout in %s: only %0d of %0d instructions reached ID",
               test_name, consumed - start_count, n);
      timeout_count++;
    end
  endtask

  // ID ready is random while back-pressure is on
  always @(posedge clk) begin
    logic [31:0] nxt;
    nxt = lfsr_next(lfsr_q);
    if (random_ready) begin
      lfsr_q     <= nxt;
      id_ready_i <= nxt[0];
    end else begin
      id_ready_i <= ready_level;
    end
  end

  ////////////////////////////////////////
  // Checker
  ////////////////////////////////////////

  always @(posedge clk) begin
    logic [`FETCH_XLEN-1:0] pc;
    pc = if_id_pc_o;
    if (!rst_n) begin
      assert (!wb_cyc_o && !wb_stb_o && !if_busy_o && !if_id_instr_valid_o &&
              !csr_mtvec_init_o)
        else note_failure("outputs are not low during reset");
    end else begin
      // Word taken by ID is compared with the model pc
      if (if_id_instr_valid_o && id_ready_i) begin
        assert (pc == exp_pc) else show_mismatch("pc", exp_pc, pc);
        assert (if_id_instr_o == (exp_pc ^ DATA_MASK))
          else show_mismatch("instr", exp_pc ^ DATA_MASK, if_id_instr_o);
        assert (if_id_abort_o == in_err_region(exp_pc))
          else show_mismatch("abort", 32'(in_err_region(exp_pc)), 32'(if_id_abort_o));
        exp_pc   <= exp_pc + 32'd4;
        consumed <= consumed + 1;
      end
      if (pc_set_i) begin
        exp_pc <= redirect_pc;
      end
      // Fetch address shows the target one cycle after a redirect
      if (redirect_q) begin
        assert (pc_if_o == exp_pc) else show_mismatch("pc_if", exp_pc, pc_if_o);
      end
      redirect_q <= pc_set_i;
      // Strobe only right after a boot redirect
      if (csr_mtvec_init_o) begin
        assert (boot_set_q) else note_failure("mtvec init strobe without a boot redirect");
        mtvec_pulses <= mtvec_pulses + 1;
      end
      boot_set_q <= pc_set_i && (pc_mux_i == PC_BOOT);
      // Frozen register under back-pressure
      if (hold_q) begin
        assert ({if_id_instr_valid_o, pc, if_id_instr_o, if_id_abort_o} === held_q)
          else note_failure("IF/ID outputs changed while ID was not ready");
      end
      hold_q <= !id_ready_i && !kill_if_i;
      held_q <= {if_id_instr_valid_o, pc, if_id_instr_o, if_id_abort_o};
      assert (!(halt_if_i && if_valid_o)) else note_failure("stage valid while halted");
      if (end_check) begin
        assert (mtvec_pulses == 1) else show_mismatch("mtvec_init_pulses", 1, mtvec_pulses);
      end
    end
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial begin
    rst_n           = 1'b0;
    pc_mux_i        = PC_BOOT;
    pc_set_i        = 1'b0;
    boot_addr_i     = 32'h0000_0102;
    jump_target_i   = '0;
    branch_target_i = '0;
    mepc_i          = '0;
    pipe_pc_i       = '0;
    mtvec_addr_i    = '0;
    irq_id_i        = '0;
    halt_if_i       = 1'b0;
    kill_if_i       = 1'b0;
    random_ready    = 1'b0;
    ready_level     = 1'b0;
    end_check       = 1'b0;
    test_name       = "reset";
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    repeat (5) @(posedge clk);

    // Unaligned boot address gives a first fetch at 0x100
    ready_level <= 1'b1;
    redirect("boot", PC_BOOT, 32'h0000_0100);
    wait_fetches(6);
    jump_target_i <= 32'h0000_2000;
    redirect("jump", PC_JUMP, 32'h0000_2000);
    wait_fetches(4);
    branch_target_i <= 32'h0000_3000;
    redirect("branch", PC_BRANCH, 32'h0000_3000);
    wait_fetches(4);
    mepc_i <= 32'h0000_4000;
    redirect("mret", PC_MRET, 32'h0000_4000);
    wait_fetches(4);
    pipe_pc_i <= 32'h0000_5004;
    redirect("wb_plus4", PC_WB_PLUS4, 32'h0000_5004);
    wait_fetches(4);

    // Vector base 0x6000 and irq 11 give 0x602C
    mtvec_addr_i <= 25'h00000C0;
    redirect("trap_exc", PC_TRAP_EXC, 32'h0000_6000);
    wait_fetches(3);
    irq_id_i <= 5'd11;
    redirect("trap_irq", PC_TRAP_IRQ, 32'h0000_602C);
    wait_fetches(3);

    // Crosses into the error region after two words
    jump_target_i <= 32'h0000_EFF8;
    redirect("bus_error", PC_JUMP, 32'h0000_EFF8);
    wait_fetches(4);

    test_name    <= "back_pressure";
    random_ready <= 1'b1;
    wait_fetches(24);
    random_ready <= 1'b0;

    test_name <= "halt";
    halt_if_i <= 1'b1;
    repeat (12) @(posedge clk);
    halt_if_i <= 1'b0;
    wait_fetches(4);

    end_check <= 1'b1;
    @(posedge clk);
    end_check <= 1'b0;
    repeat (2) @(posedge clk);

    $display("Checks done: %0d errors, %0d timeouts", error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- sources.f
+incdir+verilog
verilog/fetch_pkg.sv
verilog/fetch_resp_if.sv
verilog/fetch_pc_select.sv
verilog/wb_fetch_master.sv
verilog/fetch_queue.sv
verilog/if_id_register.sv
verilog/if_stage.sv
tb/wb_mem_model.sv
tb/tb_if_stage.sv

//--- Makefile
TOP := tb_if_stage

.PHONY: simulate clean

simulate:
	verilator --binary --timing --assert --timescale 1ns/1ps -f sources.f \
	  --top-module $(TOP) -o V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
